/* hw/rvv_div_pkg.sv */
`default_nettype none

package rvv_div_pkg;

  localparam int byte_width  = 8;
  localparam int hword_width = 16;
  localparam int word_width  = 32;

  localparam int rob_depth_width = 4;

  // divide group of the OPMVV/OPMVX space
  typedef enum logic [5:0] {
    vdivu = 6'b100000,
    vdiv  = 6'b100001,
    vremu = 6'b100010,
    vrem  = 6'b100011
  } funct6_e;

  typedef enum logic [2:0] {
    opmvv = 3'b010,
    opmvx = 3'b110
  } funct3_e;

  typedef enum logic [1:0] {
    eew8  = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  // one 32-bit slice of a vector register, read at the element width
  typedef union packed {
    logic [3:0][byte_width-1:0]  bytes;
    logic [1:0][hword_width-1:0] hwords;
    logic [word_width-1:0]       word;
  } lane_word_u;

endpackage

`default_nettype wire

/* hw/rvv_div_lane_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rvv_div_lane_if
  import rvv_div_pkg::*;
#(
  parameter int VLEN = 128
);

  // start pulses, one per divider class
  logic start8;
  logic start16;
  logic start32;

  logic is_signed;
  logic use_scalar;
  logic is_rem;
  eew_e eew;
  logic result_ack;

  // one bit per divider lane
  logic [VLEN/(2*byte_width)-1:0]  done8;
  logic [VLEN/(2*hword_width)-1:0] done16;
  logic [VLEN/word_width-1:0]      done32;

  modport ctrl (
    output start8, start16, start32,
    output is_signed, use_scalar, is_rem, eew, result_ack,
    input  done8, done16, done32
  );

  modport unpack (input is_signed, input use_scalar);

  modport pack (input is_rem, input eew);

endinterface

`default_nettype wire

/* hw/rvv_div_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_div_ctrl
  import rvv_div_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       div_uop_valid,
  input  funct6_e                    uop_funct6,
  input  funct3_e                    uop_funct3,
  input  eew_e                       vs2_eew,
  input  logic [rob_depth_width-1:0] rob_entry,
  input  logic                       result_ready,
  output logic                       result_valid,
  output logic [rob_depth_width-1:0] result_rob_entry,
  rvv_div_lane_if.ctrl               lane
);

  localparam int n8  = VLEN / (2 * byte_width);
  localparam int n16 = VLEN / (2 * hword_width);
  localparam int n32 = VLEN / word_width;

  logic f3_ok;
  logic f6_ok;
  logic rem_op;
  logic accept;
  logic busy;
  logic done8_all;
  logic done16_all;
  logic done32_all;
  logic all_done;

  always_comb begin
    f3_ok           = 1'b0;
    lane.use_scalar = 1'b0;
    case (uop_funct3)
      opmvv: f3_ok = 1'b1;
      opmvx: begin
        f3_ok           = 1'b1;
        lane.use_scalar = 1'b1;
      end
      default: f3_ok = 1'b0;
    endcase
  end

  always_comb begin
    f6_ok          = 1'b1;
    lane.is_signed = 1'b0;
    rem_op         = 1'b0;
    case (uop_funct6)
      vdivu: f6_ok = 1'b1;
      vdiv:  lane.is_signed = 1'b1;
      vremu: rem_op = 1'b1;
      vrem: begin
        lane.is_signed = 1'b1;
        rem_op         = 1'b1;
      end
      default: f6_ok = 1'b0;
    endcase
  end

  // unsupported ops and pulses during a pending result are dropped
  assign accept = div_uop_valid & ~busy & f3_ok & f6_ok;

  assign lane.start32 = accept;
  assign lane.start16 = accept & ((vs2_eew == eew8) | (vs2_eew == eew16));
  assign lane.start8  = accept & (vs2_eew == eew8);

  assign done8_all  = (lane.done8 == {n8{1'b1}});
  assign done16_all = (lane.done16 == {n16{1'b1}});
  assign done32_all = (lane.done32 == {n32{1'b1}});

  // only the classes in use at the captured width
  always_comb begin
    case (lane.eew)
      eew8:    all_done = done8_all & done16_all & done32_all;
      eew16:   all_done = done16_all & done32_all;
      default: all_done = done32_all;
    endcase
  end

  assign result_valid    = busy & all_done;
  assign lane.result_ack = result_valid & result_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      lane.eew    <= eew8;
      lane.is_rem <= 1'b0;
    end else if (accept) begin
      busy        <= 1'b1;
      lane.eew    <= vs2_eew;
      lane.is_rem <= rem_op;
    end else if (lane.result_ack) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result_rob_entry <= rob_entry;
    end
  end

endmodule

`default_nettype wire

/* hw/rvv_div_operand_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_div_operand_unpack
  import rvv_div_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic [VLEN-1:0]                                  vs1_data,
  input  logic [VLEN-1:0]                                  vs2_data,
  input  logic [word_width-1:0]                            rs1_data,
  input  eew_e                                             vs2_eew,
  rvv_div_lane_if.unpack                                   lane,
  output logic [VLEN/(2*byte_width)-1:0][byte_width-1:0]   dividend8,
  output logic [VLEN/(2*byte_width)-1:0][byte_width-1:0]   divisor8,
  output logic [VLEN/(2*hword_width)-1:0][hword_width-1:0] dividend16,
  output logic [VLEN/(2*hword_width)-1:0][hword_width-1:0] divisor16,
  output logic [VLEN/word_width-1:0][word_width-1:0]       dividend32,
  output logic [VLEN/word_width-1:0][word_width-1:0]       divisor32
);

  localparam int n_words = VLEN / word_width;
  localparam int n8      = VLEN / (2 * byte_width);
  localparam int n16     = VLEN / (2 * hword_width);
  localparam int n32     = VLEN / word_width;

  lane_word_u [n_words-1:0] src1_w;
  lane_word_u [n_words-1:0] src2_w;
  lane_word_u               scalar_w;

  assign src1_w   = vs1_data;
  assign src2_w   = vs2_data;
  assign scalar_w = rs1_data;

  // element k out of its word, widened to 32 bits
  function automatic logic [word_width-1:0] extend(lane_word_u w, int k, eew_e eew, logic sgn);
    logic [word_width-1:0] e;
    case (eew)
      eew8: e = {{(word_width-byte_width){sgn & w.bytes[k%4][byte_width-1]}},
                 w.bytes[k%4]};
      eew16: e = {{(word_width-hword_width){sgn & w.hwords[k%2][hword_width-1]}},
                  w.hwords[k%2]};
      default: e = w.word;
    endcase
    return e;
  endfunction

  always_comb begin
    int shift;
    int base16;
    int base32;
    int k;
    logic [word_width-1:0] s;
    logic [word_width-1:0] a;
    logic [word_width-1:0] d;

    k = 0;
    s = extend(scalar_w, 0, vs2_eew, lane.is_signed);
    case (vs2_eew)
      eew8: begin
        shift  = 2;
        base16 = n8;
        base32 = n8 + n16;
      end
      eew16: begin
        shift  = 1;
        base16 = 0;
        base32 = n16;
      end
      default: begin
        shift  = 0;
        base16 = 0;
        base32 = 0;
      end
    endcase

    // byte lanes only carry elements at eew8
    for (int j = 0; j < n8; j++) begin
      a = '0;
      d = '0;
      if (vs2_eew == eew8) begin
        a = extend(src2_w[j >> shift], j, vs2_eew, lane.is_signed);
        d = lane.use_scalar ? s : extend(src1_w[j >> shift], j, vs2_eew, lane.is_signed);
      end
      dividend8[j] = a[byte_width-1:0];
      divisor8[j]  = d[byte_width-1:0];
    end

    for (int j = 0; j < n16; j++) begin
      k = base16 + j;
      a = extend(src2_w[k >> shift], k, vs2_eew, lane.is_signed);
      d = lane.use_scalar ? s : extend(src1_w[k >> shift], k, vs2_eew, lane.is_signed);
      dividend16[j] = a[hword_width-1:0];
      divisor16[j]  = d[hword_width-1:0];
    end

    for (int j = 0; j < n32; j++) begin
      k = base32 + j;
      dividend32[j] = extend(src2_w[k >> shift], k, vs2_eew, lane.is_signed);
      divisor32[j]  = lane.use_scalar ? s :
                      extend(src1_w[k >> shift], k, vs2_eew, lane.is_signed);
    end
  end

endmodule

`default_nettype wire

/* hw/rvv_div_lane_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_div_lane_divider #(
  parameter int DIV_WIDTH = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 is_signed,
  input  logic                 result_ack,
  input  logic [DIV_WIDTH-1:0] dividend,
  input  logic [DIV_WIDTH-1:0] divisor,
  output logic [DIV_WIDTH-1:0] quotient,
  output logic [DIV_WIDTH-1:0] remainder,
  output logic                 done
);

  localparam int               cnt_w    = $clog2(DIV_WIDTH);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(DIV_WIDTH - 1);

  logic                 busy;
  logic [cnt_w-1:0]     cnt;
  logic [DIV_WIDTH-1:0] rem_q;
  logic [DIV_WIDTH-1:0] quo_q;
  logic [DIV_WIDTH-1:0] dsr_q;
  logic [DIV_WIDTH-1:0] dvd_q;
  logic                 neg_quo;
  logic                 neg_rem;
  logic                 by_zero;

  logic                 dvd_neg;
  logic                 dsr_neg;
  logic [DIV_WIDTH-1:0] dvd_mag;
  logic [DIV_WIDTH-1:0] dsr_mag;
  logic [DIV_WIDTH:0]   shifted;
  logic [DIV_WIDTH:0]   diff;
  logic                 fits;
  logic [DIV_WIDTH-1:0] rem_step;
  logic [DIV_WIDTH-1:0] quo_step;
  logic [DIV_WIDTH-1:0] quo_fix;
  logic [DIV_WIDTH-1:0] rem_fix;

  assign dvd_neg = is_signed & dividend[DIV_WIDTH-1];
  assign dsr_neg = is_signed & divisor[DIV_WIDTH-1];
  assign dvd_mag = dvd_neg ? -dividend : dividend;
  assign dsr_mag = dsr_neg ? -divisor : divisor;

  // bring down the next dividend bit and try the divisor
  assign shifted  = {rem_q, quo_q[DIV_WIDTH-1]};
  assign diff     = shifted - {1'b0, dsr_q};
  assign fits     = shifted >= {1'b0, dsr_q};
  assign rem_step = fits ? diff[DIV_WIDTH-1:0] : shifted[DIV_WIDTH-1:0];
  assign quo_step = {quo_q[DIV_WIDTH-2:0], fits};

  // min / -1 comes out as the dividend through the magnitude path
  always_comb begin
    if (by_zero) begin
      quo_fix = '1;
      rem_fix = dvd_q;
    end else begin
      quo_fix = neg_quo ? -quo_step : quo_step;
      rem_fix = neg_rem ? -rem_step : rem_step;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
      cnt  <= '0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (cnt == last_cnt) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else if (result_ack) begin
      done <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rem_q   <= '0;
      quo_q   <= dvd_mag;
      dsr_q   <= dsr_mag;
      dvd_q   <= dividend;
      neg_quo <= dvd_neg ^ dsr_neg;
      neg_rem <= dvd_neg;
      by_zero <= (divisor == '0);
    end else if (busy) begin
      // last step also fixes signs, then the result sits here until ack
      if (cnt == last_cnt) begin
        rem_q <= rem_fix;
        quo_q <= quo_fix;
      end else begin
        rem_q <= rem_step;
        quo_q <= quo_step;
      end
    end
  end

  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

`default_nettype wire

/* hw/rvv_div_result_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_div_result_pack
  import rvv_div_pkg::*;
#(
  parameter int VLEN = 128
) (
  rvv_div_lane_if.pack                                    lane,
  input  logic [VLEN/(2*byte_width)-1:0][byte_width-1:0]   quotient8,
  input  logic [VLEN/(2*byte_width)-1:0][byte_width-1:0]   remainder8,
  input  logic [VLEN/(2*hword_width)-1:0][hword_width-1:0] quotient16,
  input  logic [VLEN/(2*hword_width)-1:0][hword_width-1:0] remainder16,
  input  logic [VLEN/word_width-1:0][word_width-1:0]       quotient32,
  input  logic [VLEN/word_width-1:0][word_width-1:0]       remainder32,
  output logic [VLEN-1:0]                                  result_data
);

  localparam int n_words = VLEN / word_width;
  localparam int n8      = VLEN / (2 * byte_width);
  localparam int n16     = VLEN / (2 * hword_width);
  localparam int n32     = VLEN / word_width;

  logic [n8-1:0][byte_width-1:0]   res8;
  logic [n16-1:0][hword_width-1:0] res16;
  logic [n32-1:0][word_width-1:0]  res32;
  lane_word_u [n_words-1:0]        out_w;

  assign res8  = lane.is_rem ? remainder8 : quotient8;
  assign res16 = lane.is_rem ? remainder16 : quotient16;
  assign res32 = lane.is_rem ? remainder32 : quotient32;

  // same element order as the unpack, low lanes first
  always_comb begin
    int k;

    k     = 0;
    out_w = '0;
    case (lane.eew)
      eew8: begin
        for (int j = 0; j < n8; j++) begin
          out_w[j/4].bytes[j%4] = res8[j];
        end
        for (int j = 0; j < n16; j++) begin
          k = n8 + j;
          out_w[k/4].bytes[k%4] = res16[j][byte_width-1:0];
        end
        for (int j = 0; j < n32; j++) begin
          k = n8 + n16 + j;
          out_w[k/4].bytes[k%4] = res32[j][byte_width-1:0];
        end
      end
      eew16: begin
        for (int j = 0; j < n16; j++) begin
          out_w[j/2].hwords[j%2] = res16[j];
        end
        for (int j = 0; j < n32; j++) begin
          k = n16 + j;
          out_w[k/2].hwords[k%2] = res32[j][hword_width-1:0];
        end
      end
      default: begin
        for (int j = 0; j < n32; j++) begin
          out_w[j].word = res32[j];
        end
      end
    endcase
  end

  assign result_data = out_w;

endmodule

`default_nettype wire

/* hw/rvv_div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_div_unit
  import rvv_div_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       div_uop_valid,
  input  funct6_e                    uop_funct6,
  input  funct3_e                    uop_funct3,
  input  eew_e                       vs2_eew,
  input  logic [VLEN-1:0]            vs1_data,
  input  logic [VLEN-1:0]            vs2_data,
  input  logic [word_width-1:0]      rs1_data,
  input  logic [rob_depth_width-1:0] rob_entry,
  output logic                       result_valid,
  input  logic                       result_ready,
  output logic [rob_depth_width-1:0] result_rob_entry,
  output logic [VLEN-1:0]            result_data
);

  localparam int n8  = VLEN / (2 * byte_width);
  localparam int n16 = VLEN / (2 * hword_width);
  localparam int n32 = VLEN / word_width;

  logic [n8-1:0][byte_width-1:0]   dividend8;
  logic [n8-1:0][byte_width-1:0]   divisor8;
  logic [n8-1:0][byte_width-1:0]   quotient8;
  logic [n8-1:0][byte_width-1:0]   remainder8;
  logic [n16-1:0][hword_width-1:0] dividend16;
  logic [n16-1:0][hword_width-1:0] divisor16;
  logic [n16-1:0][hword_width-1:0] quotient16;
  logic [n16-1:0][hword_width-1:0] remainder16;
  logic [n32-1:0][word_width-1:0]  dividend32;
  logic [n32-1:0][word_width-1:0]  divisor32;
  logic [n32-1:0][word_width-1:0]  quotient32;
  logic [n32-1:0][word_width-1:0]  remainder32;

  rvv_div_lane_if #(.VLEN(VLEN)) lane ();

  rvv_div_ctrl #(.VLEN(VLEN)) u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .div_uop_valid    (div_uop_valid),
    .uop_funct6       (uop_funct6),
    .uop_funct3       (uop_funct3),
    .vs2_eew          (vs2_eew),
    .rob_entry        (rob_entry),
    .result_ready     (result_ready),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .lane             (lane.ctrl)
  );

  rvv_div_operand_unpack #(.VLEN(VLEN)) u_unpack (
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .rs1_data   (rs1_data),
    .vs2_eew    (vs2_eew),
    .lane       (lane.unpack),
    .dividend8  (dividend8),
    .divisor8   (divisor8),
    .dividend16 (dividend16),
    .divisor16  (divisor16),
    .dividend32 (dividend32),
    .divisor32  (divisor32)
  );

  for (genvar j = 0; j < n8; j++) begin : g_div8
    rvv_div_lane_divider #(.DIV_WIDTH(byte_width)) u_div (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (lane.start8),
      .is_signed  (lane.is_signed),
      .result_ack (lane.result_ack),
      .dividend   (dividend8[j]),
      .divisor    (divisor8[j]),
      .quotient   (quotient8[j]),
      .remainder  (remainder8[j]),
      .done       (lane.done8[j])
    );
  end

  for (genvar j = 0; j < n16; j++) begin : g_div16
    rvv_div_lane_divider #(.DIV_WIDTH(hword_width)) u_div (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (lane.start16),
      .is_signed  (lane.is_signed),
      .result_ack (lane.result_ack),
      .dividend   (dividend16[j]),
      .divisor    (divisor16[j]),
      .quotient   (quotient16[j]),
      .remainder  (remainder16[j]),
      .done       (lane.done16[j])
    );
  end

  for (genvar j = 0; j < n32; j++) begin : g_div32
    rvv_div_lane_divider #(.DIV_WIDTH(word_width)) u_div (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (lane.start32),
      .is_signed  (lane.is_signed),
      .result_ack (lane.result_ack),
      .dividend   (dividend32[j]),
      .divisor    (divisor32[j]),
      .quotient   (quotient32[j]),
      .remainder  (remainder32[j]),
      .done       (lane.done32[j])
    );
  end

  rvv_div_result_pack #(.VLEN(VLEN)) u_pack (
    .lane        (lane.pack),
    .quotient8   (quotient8),
    .remainder8  (remainder8),
    .quotient16  (quotient16),
    .remainder16 (remainder16),
    .quotient32  (quotient32),
    .remainder32 (remainder32),
    .result_data (result_data)
  );

endmodule

`default_nettype wire

/* verification/rvv_div_ref_pkg.sv */
`default_nettype none

package rvv_div_ref_pkg;
  import rvv_div_pkg::*;

  localparam int max_vlen = 256;

  function automatic int elem_bits(eew_e eew);
    case (eew)
      eew8:    return byte_width;
      eew16:   return hword_width;
      default: return word_width;
    endcase
  endfunction

  function automatic logic [31:0] elem_mask(int sew);
    return (sew >= 32) ? 32'hffff_ffff : (32'd1 << sew) - 32'd1;
  endfunction

  // element as an integer, sign taken from bit sew-1 when signed
  function automatic longint to_int(logic [31:0] v, int sew, logic sgn);
    longint x;
    x = longint'(v & elem_mask(sew));
    if (sgn && v[sew-1]) begin
      x = x - (longint'(1) << sew);
    end
    return x;
  endfunction

  function automatic logic op_supported(funct6_e f6, funct3_e f3);
    logic f6_ok;
    logic f3_ok;
    f6_ok = (f6 == vdivu) || (f6 == vdiv) || (f6 == vremu) || (f6 == vrem);
    f3_ok = (f3 == opmvv) || (f3 == opmvx);
    return f6_ok && f3_ok;
  endfunction

  // RISC-V divide rules for one element
  function automatic logic [31:0] elem_result(logic [31:0] a, logic [31:0] b, int sew,
                                              logic sgn, logic rem);
    longint      x;
    longint      y;
    longint      q;
    longint      r;
    logic [63:0] res;
    x = to_int(a, sew, sgn);
    y = to_int(b, sew, sgn);
    if (y == 0) begin
      q = -1;
      r = x;
    end else if (sgn && y == -1 && x == -(longint'(1) << (sew - 1))) begin
      q = x;
      r = 0;
    end else begin
      q = x / y;
      r = x % y;
    end
    res = rem ? r : q;
    return res[31:0] & elem_mask(sew);
  endfunction

  function automatic logic [max_vlen-1:0] vec_result(funct6_e f6, funct3_e f3, eew_e eew,
                                                     logic [max_vlen-1:0] vs1,
                                                     logic [max_vlen-1:0] vs2,
                                                     logic [31:0] rs1, int vlen);
    int                  sew;
    logic                sgn;
    logic                rem;
    logic [31:0]         a;
    logic [31:0]         b;
    logic [max_vlen-1:0] res;
    sew = elem_bits(eew);
    sgn = (f6 == vdiv) || (f6 == vrem);
    rem = (f6 == vremu) || (f6 == vrem);
    res = '0;
    for (int k = 0; k < vlen / sew; k++) begin
      a   = 32'(vs2 >> (k * sew));
      b   = (f3 == opmvx) ? rs1 : 32'(vs1 >> (k * sew));
      res = res | (max_vlen'(elem_result(a, b, sew, sgn, rem)) << (k * sew));
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* verification/rvv_div_unit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_div_unit_sva
  import rvv_div_pkg::*;
#(
  parameter int VLEN = 128
) (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       div_uop_valid,
  input logic                       accept,
  input logic                       result_valid,
  input logic                       result_ready,
  input logic [rob_depth_width-1:0] result_rob_entry,
  input logic [VLEN-1:0]            result_data
);

  // failed assertions so far
  int n_failures = 0;

  // result held under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result_ready |=>
      result_valid && $stable(result_data) && $stable(result_rob_entry))
    else begin
      $error("result changed while result_ready was low");
      n_failures++;
    end

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> !result_valid [*32])
    else begin
      $error("result_valid rose too early after an accepted op");
      n_failures++;
    end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(div_uop_valid && result_valid))
    else begin
      $error("div_uop_valid pulsed while a result was pending");
      n_failures++;
    end

endmodule

bind rvv_div_unit rvv_div_unit_sva #(.VLEN(VLEN)) u_sva (
  .clk              (clk),
  .rst_n            (rst_n),
  .div_uop_valid    (div_uop_valid),
  .accept           (u_ctrl.accept),
  .result_valid     (result_valid),
  .result_ready     (result_ready),
  .result_rob_entry (result_rob_entry),
  .result_data      (result_data)
);

`default_nettype wire

/* verification/tb_rvv_div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_div_unit
  import rvv_div_pkg::*;
  import rvv_div_ref_pkg::*;
();

  localparam int vlen         = 128;
  localparam int clk_period   = 20;
  localparam int reset_cycles = 10;
  localparam int n_ops        = 400;
  localparam int latency      = 32;
  localparam int idle_window  = 40;

  logic                       clk;
  logic                       rst_n;
  logic                       div_uop_valid;
  funct6_e                    uop_funct6;
  funct3_e                    uop_funct3;
  eew_e                       vs2_eew;
  logic [vlen-1:0]            vs1_data;
  logic [vlen-1:0]            vs2_data;
  logic [word_width-1:0]      rs1_data;
  logic [rob_depth_width-1:0] rob_entry;
  logic                       result_valid;
  logic                       result_ready;
  logic [rob_depth_width-1:0] result_rob_entry;
  logic [vlen-1:0]            result_data;

  rvv_div_unit #(.VLEN(vlen)) u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .div_uop_valid    (div_uop_valid),
    .uop_funct6       (uop_funct6),
    .uop_funct3       (uop_funct3),
    .vs2_eew          (vs2_eew),
    .vs1_data         (vs1_data),
    .vs2_data         (vs2_data),
    .rs1_data         (rs1_data),
    .rob_entry        (rob_entry),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #((n_ops * 60 + reset_cycles) * clk_period);
    $display("watchdog expired before all ops completed");
    report_failure();
  end

  // the bound checker counts its own assertion failures
  initial begin
    wait (u_dut.u_sva.n_failures != 0);
    $display("a concurrent assertion on the DUT failed");
    report_failure();
  end

  task automatic report_failure();
    $display("*** FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string name, input logic [vlen-1:0] actual,
                            input logic [vlen-1:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      report_failure();
    end
  endtask

  task automatic check_rob(input string name, input logic [rob_depth_width-1:0] actual,
                           input logic [rob_depth_width-1:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
               $time, name, expected, actual);
      report_failure();
    end
  endtask

  task automatic check_latency(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
               $time, name, expected, actual);
      report_failure();
    end
  endtask

  // corner values show up often enough to hit div by zero and overflow
  function automatic logic [31:0] random_element(int sew);
    logic [31:0] e;
    case ($urandom % 8)
      0:       e = '0;
      1:       e = '1;
      2:       e = 32'd1 << (sew - 1);
      default: e = $urandom;
    endcase
    return e & elem_mask(sew);
  endfunction

  function automatic logic [vlen-1:0] random_vector(int sew);
    logic [vlen-1:0] v;
    v = '0;
    for (int k = 0; k < vlen / sew; k++) begin
      v = v | (vlen'(random_element(sew)) << (k * sew));
    end
    return v;
  endfunction

  // returns on the accepting edge
  task automatic issue_op(input funct6_e f6, input funct3_e f3, input eew_e eew,
                          input logic [vlen-1:0] vs1, input logic [vlen-1:0] vs2,
                          input logic [word_width-1:0] rs1,
                          input logic [rob_depth_width-1:0] rob);
    @(posedge clk);
    div_uop_valid <= 1'b1;
    uop_funct6    <= f6;
    uop_funct3    <= f3;
    vs2_eew       <= eew;
    vs1_data      <= vs1;
    vs2_data      <= vs2;
    rs1_data      <= rs1;
    rob_entry     <= rob;
    result_ready  <= 1'($urandom % 2);
    @(posedge clk);
    div_uop_valid <= 1'b0;
  endtask

  task automatic wait_result();
    int lat;
    lat = 0;
    @(negedge clk);
    while (!result_valid) begin
      if (lat >= idle_window) begin
        $display("no result within %0d cycles of an accepted op", idle_window);
        report_failure();
      end
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    check_latency("result_valid latency", lat, latency);
  endtask

  task automatic drain_result(input logic [vlen-1:0] exp_data,
                              input logic [rob_depth_width-1:0] exp_rob);
    logic acked;
    int   held;
    acked = 1'b0;
    held  = 0;
    while (!acked) begin
      check_flag("result_valid", result_valid, 1'b1);
      check_data("result_data", result_data, exp_data);
      check_rob("result_rob_entry", result_rob_entry, exp_rob);
      @(posedge clk);
      if (result_ready) begin
        acked = 1'b1;
        result_ready <= 1'b0;
      end else begin
        held++;
        result_ready <= (held >= 8) || ($urandom % 3 == 0);
      end
      @(negedge clk);
    end
    check_flag("result_valid", result_valid, 1'b0);
  endtask

  // an ignored op must leave the output quiet
  task automatic watch_idle();
    for (int c = 0; c < idle_window; c++) begin
      @(negedge clk);
      check_flag("result_valid", result_valid, 1'b0);
    end
  endtask

  initial begin
    funct6_e                    f6;
    funct3_e                    f3;
    eew_e                       eew;
    int                         sew;
    int                         n_checked;
    logic                       ok;
    logic [vlen-1:0]            vs1;
    logic [vlen-1:0]            vs2;
    logic [word_width-1:0]      rs1;
    logic [rob_depth_width-1:0] rob;
    logic [vlen-1:0]            exp_data;

    void'($urandom(32));
    n_checked     = 0;
    rst_n         = 1'b0;
    div_uop_valid = 1'b0;
    uop_funct6    = vdivu;
    uop_funct3    = opmvv;
    vs2_eew       = eew8;
    vs1_data      = '0;
    vs2_data      = '0;
    rs1_data      = '0;
    rob_entry     = '0;
    result_ready  = 1'b0;

    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("result_valid", result_valid, 1'b0);

    for (int i = 0; i < n_ops; i++) begin
      eew = eew_e'($urandom % 3);
      sew = elem_bits(eew);
      if ($urandom % 10 == 0) begin
        f6 = funct6_e'(6'h28 + 6'($urandom % 8));
      end else begin
        f6 = funct6_e'(6'h20 + 6'($urandom % 4));
      end
      if ($urandom % 20 == 0) begin
        f3 = funct3_e'(3'($urandom % 2));
      end else begin
        f3 = ($urandom % 2 == 0) ? opmvv : opmvx;
      end
      vs1 = random_vector(sew);
      vs2 = random_vector(sew);
      rs1 = $urandom;
      rs1 = (rs1 & ~elem_mask(sew)) | random_element(sew);
      rob = rob_depth_width'($urandom);

      ok       = op_supported(f6, f3);
      exp_data = vlen'(vec_result(f6, f3, eew, vs1, vs2, rs1, vlen));

      issue_op(f6, f3, eew, vs1, vs2, rs1, rob);
      if (ok) begin
        wait_result();
        drain_result(exp_data, rob);
        n_checked++;
      end else begin
        watch_idle();
      end
    end

    if (u_dut.u_sva.n_failures == 0) begin
      $display("%0d ops issued, %0d results checked", n_ops, n_checked);
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "assertion failures found");
    end
  end

endmodule

`default_nettype wire

/* list.f */
hw/rvv_div_pkg.sv
hw/rvv_div_lane_if.sv
hw/rvv_div_ctrl.sv
hw/rvv_div_operand_unpack.sv
hw/rvv_div_lane_divider.sv
hw/rvv_div_result_pack.sv
hw/rvv_div_unit.sv
verification/rvv_div_ref_pkg.sv
verification/rvv_div_unit_sva.sv
verification/tb_rvv_div_unit.sv
